// ==== design/riscv_params.svh ====
`ifndef RISCV_PARAMS_SVH
`define RISCV_PARAMS_SVH

// Register and data width
`define XLEN 32

// Program counter, byte address into instruction memory
`define PC_W 12

// Data memory word address
`define DADDR_W 12

`define RESET_PC 12'h000

// Full EBREAK encoding
`define EBREAK_INSN 32'h0010_0073

`endif

// ==== design/riscvPkg.sv ====
package riscvPkg;

	// RV32I major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		opLui    = 7'b0110111,
		opAuipc  = 7'b0010111,
		opJal    = 7'b1101111,
		opJalr   = 7'b1100111,
		opBranch = 7'b1100011,
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opOpImm  = 7'b0010011,
		opOp     = 7'b0110011,
		opSystem = 7'b1110011
	} opcodeE;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluSll,
		aluSlt,
		aluSltu,
		aluXor,
		aluSrl,
		aluSra,
		aluOr,
		aluAnd,
		aluPassB // Operand B straight through, for LUI
	} aluOpE;

	typedef enum logic [1:0] {
		wbAlu,
		wbMem,
		wbLink // pc + 4
	} wbSelE;

	typedef enum logic [1:0] {
		pcSeq,
		pcBranch,
		pcJal,
		pcJalr
	} pcSelE;

endpackage

// ==== design/riscvDecode.sv ====
`include "riscv_params.svh"

module riscvDecode (
	input  logic [`XLEN-1:0]    instr,
	output logic [4:0]          rs1,
	output logic [4:0]          rs2,
	output logic [4:0]          rd,
	output logic [`XLEN-1:0]    imm,
	output riscvPkg::aluOpE     aluOp,
	output logic                aluSrcImm,
	output logic                aluSrcPc,
	output logic [2:0]          branchFunct,
	output riscvPkg::wbSelE     wbSel,
	output riscvPkg::pcSelE     pcSel,
	output logic                regWrite,
	output logic                memWrite,
	output logic                memRead,
	output logic                isHalt
);
	import riscvPkg::*;

	opcodeE           opcode;
	logic [2:0]       funct3;
	logic             funct7b5;
	logic [`XLEN-1:0] immI;
	logic [`XLEN-1:0] immS;
	logic [`XLEN-1:0] immB;
	logic [`XLEN-1:0] immU;
	logic [`XLEN-1:0] immJ;

	// funct7 bit 5 picks SUB only for register ops and SRA for both
	function automatic aluOpE aluFromFunct(input logic [2:0] f3, input logic f7b5,
			input logic isReg);
		aluOpE op;
		case (f3)
			3'b000: op = (isReg && f7b5) ? aluSub : aluAdd;
			3'b001: op = aluSll;
			3'b010: op = aluSlt;
			3'b011: op = aluSltu;
			3'b100: op = aluXor;
			3'b101: op = f7b5 ? aluSra : aluSrl;
			3'b110: op = aluOr;
			default: op = aluAnd;
		endcase
		return op;
	endfunction

	assign opcode   = opcodeE'(instr[6:0]);
	assign funct3   = instr[14:12];
	assign funct7b5 = instr[30];

	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign rd  = instr[11:7];

	assign immI = {{(`XLEN-12){instr[31]}}, instr[31:20]};
	assign immS = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{(`XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immU = {instr[31:12], 12'b0};
	assign immJ = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	assign branchFunct = funct3;
	assign isHalt      = (instr == `EBREAK_INSN);

	always_comb begin
		imm       = immI;
		aluOp     = aluAdd;
		aluSrcImm = 1'b0;
		aluSrcPc  = 1'b0;
		wbSel     = wbAlu;
		pcSel     = pcSeq;
		regWrite  = 1'b0;
		memWrite  = 1'b0;
		memRead   = 1'b0;
		case (opcode)
			opLui: begin
				imm       = immU;
				aluOp     = aluPassB;
				aluSrcImm = 1'b1;
				regWrite  = 1'b1;
			end
			opAuipc: begin
				imm       = immU;
				aluSrcImm = 1'b1;
				aluSrcPc  = 1'b1; // A = pc
				regWrite  = 1'b1;
			end
			opJal: begin
				imm      = immJ;
				wbSel    = wbLink;
				pcSel    = pcJal;
				regWrite = 1'b1;
			end
			opJalr: begin
				aluSrcImm = 1'b1; // Target is rs1 + imm
				wbSel     = wbLink;
				pcSel     = pcJalr;
				regWrite  = 1'b1;
			end
			opBranch: begin
				imm   = immB;
				pcSel = pcBranch;
			end
			opLoad: begin
				aluSrcImm = 1'b1;
				wbSel     = wbMem;
				regWrite  = 1'b1;
				memRead   = 1'b1;
			end
			opStore: begin
				imm       = immS;
				aluSrcImm = 1'b1;
				memWrite  = 1'b1;
			end
			opOpImm: begin
				aluOp     = aluFromFunct(funct3, funct7b5, 1'b0);
				aluSrcImm = 1'b1;
				regWrite  = 1'b1;
			end
			opOp: begin
				aluOp    = aluFromFunct(funct3, funct7b5, 1'b1);
				regWrite = 1'b1;
			end
			default: ; // SYSTEM and unknown opcodes retire as no-ops
		endcase
	end

endmodule

// ==== design/riscvExecute.sv ====
`include "riscv_params.svh"

module riscvExecute (
	input  logic [`XLEN-1:0] rd1,
	input  logic [`XLEN-1:0] rd2,
	input  logic [`XLEN-1:0] imm,
	input  logic [`PC_W-1:0] pc,
	input  riscvPkg::aluOpE  aluOp,
	input  logic             aluSrcImm,
	input  logic             aluSrcPc,
	input  logic [2:0]       branchFunct,
	output logic [`XLEN-1:0] aluResult,
	output logic             branchTaken
);
	import riscvPkg::*;

	logic [`XLEN-1:0] opA;
	logic [`XLEN-1:0] opB;
	logic [4:0]       shamt;

	assign opA   = aluSrcPc ? {{(`XLEN-`PC_W){1'b0}}, pc} : rd1;
	assign opB   = aluSrcImm ? imm : rd2;
	assign shamt = opB[4:0]; // Only the low 5 bits shift

	always_comb begin
		case (aluOp)
			aluAdd:   aluResult = opA + opB;
			aluSub:   aluResult = opA - opB;
			aluSll:   aluResult = opA << shamt;
			aluSlt: begin
				aluResult = ($signed(opA) < $signed(opB)) ? `XLEN'd1 : `XLEN'd0;
			end
			aluSltu: begin
				aluResult = (opA < opB) ? `XLEN'd1 : `XLEN'd0;
			end
			aluXor:   aluResult = opA ^ opB;
			aluSrl:   aluResult = opA >> shamt;
			aluSra:   aluResult = $unsigned($signed(opA) >>> shamt);
			aluOr:    aluResult = opA | opB;
			aluAnd:   aluResult = opA & opB;
			aluPassB: aluResult = opB;
			default:  aluResult = '0;
		endcase
	end

	// Branch compare works on rs1 and rs2 rather than the muxed operands
	always_comb begin
		case (branchFunct)
			3'b000:  branchTaken = (rd1 == rd2);                   // BEQ
			3'b001:  branchTaken = (rd1 != rd2);                   // BNE
			3'b100:  branchTaken = ($signed(rd1) < $signed(rd2));  // BLT
			3'b101:  branchTaken = ($signed(rd1) >= $signed(rd2)); // BGE
			3'b110:  branchTaken = (rd1 < rd2);                    // BLTU
			3'b111:  branchTaken = (rd1 >= rd2);                   // BGEU
			default: branchTaken = 1'b0;
		endcase
	end

endmodule

// ==== design/riscvResult.sv ====
`include "riscv_params.svh"

module riscvResult (
	input  logic             CLK,
	input  logic             RSTn,
	input  logic [`XLEN-1:0] aluResult,
	input  logic [`XLEN-1:0] imm,
	input  logic [`XLEN-1:0] memData,
	input  logic             branchTaken,
	input  riscvPkg::wbSelE  wbSel,
	input  riscvPkg::pcSelE  pcSel,
	input  logic             regWrite,
	input  logic             isHalt,
	output logic [`PC_W-1:0] pc,
	output logic             rfWe,
	output logic [`XLEN-1:0] rfWd,
	output logic             halt,
	output logic [31:0]      numInst
);
	import riscvPkg::*;

	logic [`PC_W-1:0] pcPlus4;
	logic [`PC_W-1:0] pcTarget;
	logic [`PC_W-1:0] jalrTarget;
	logic [`PC_W-1:0] nextPc;

	assign pcPlus4    = pc + `PC_W'd4;
	assign pcTarget   = pc + imm[`PC_W-1:0];
	assign jalrTarget = aluResult[`PC_W-1:0] & ~`PC_W'd1; // Clear bit 0

	// PC holds on EBREAK, so the fetched word keeps halt high
	assign halt = isHalt && !RSTn;
	assign rfWe = regWrite && !RSTn && !halt;

	always_comb begin
		case (wbSel)
			wbMem:   rfWd = memData;
			wbLink:  rfWd = {{(`XLEN-`PC_W){1'b0}}, pcPlus4};
			default: rfWd = aluResult;
		endcase
	end

	always_comb begin
		case (pcSel)
			pcBranch: nextPc = branchTaken ? pcTarget : pcPlus4;
			pcJal:    nextPc = pcTarget;
			pcJalr:   nextPc = jalrTarget;
			default:  nextPc = pcPlus4;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc      <= `RESET_PC;
			numInst <= '0;
		end else if (!halt) begin
			pc      <= nextPc;
			numInst <= numInst + 32'd1; // One commit per cycle
		end
	end

	aPcAligned: assert property (@(posedge CLK) disable iff (RSTn)
		pc[1:0] == 2'b00)
		else $error("result: pc %h not word aligned", pc);

	// Halt freezes fetch until the next reset
	aPcHoldOnHalt: assert property (@(posedge CLK) disable iff (RSTn)
		halt |=> (halt && $stable(pc)))
		else $error("result: halt dropped or pc moved while halted");

endmodule

// ==== design/riscvTop.sv ====
`include "riscv_params.svh"

module riscvTop (
	input  logic                CLK,
	input  logic                RSTn,

	output logic                iMemCsn,
	output logic [`PC_W-1:0]    iMemAddr,   // Byte address
	input  logic [`XLEN-1:0]    iMemDi,

	output logic                dMemCsn,
	output logic [`DADDR_W-1:0] dMemAddr,   // Word address
	output logic [`XLEN-1:0]    dMemDout,
	input  logic [`XLEN-1:0]    dMemDi,
	output logic                dMemWen,
	output logic [3:0]          dMemBe,

	output logic                rfWe,
	output logic [4:0]          rfRa1,
	output logic [4:0]          rfRa2,
	output logic [4:0]          rfWa1,
	output logic [`XLEN-1:0]    rfWd,
	input  logic [`XLEN-1:0]    rfRd1,
	input  logic [`XLEN-1:0]    rfRd2,

	output logic                halt,
	output logic [31:0]         numInst,
	output logic [`XLEN-1:0]    outputPort
);
	import riscvPkg::*;

	logic [`XLEN-1:0] imm;
	aluOpE            aluOp;
	logic             aluSrcImm;
	logic             aluSrcPc;
	logic [2:0]       branchFunct;
	wbSelE            wbSel;
	pcSelE            pcSel;
	logic             regWrite;
	logic             memWrite;
	logic             memRead;
	logic             isHalt;
	logic [`XLEN-1:0] aluResult;
	logic             branchTaken;
	logic [`PC_W-1:0] pc;

	riscvDecode uDecode (
		.instr(iMemDi),
		.rs1(rfRa1),
		.rs2(rfRa2),
		.rd(rfWa1),
		.imm(imm),
		.aluOp(aluOp),
		.aluSrcImm(aluSrcImm),
		.aluSrcPc(aluSrcPc),
		.branchFunct(branchFunct),
		.wbSel(wbSel),
		.pcSel(pcSel),
		.regWrite(regWrite),
		.memWrite(memWrite),
		.memRead(memRead),
		.isHalt(isHalt)
	);

	riscvExecute uExecute (
		.rd1(rfRd1),
		.rd2(rfRd2),
		.imm(imm),
		.pc(pc),
		.aluOp(aluOp),
		.aluSrcImm(aluSrcImm),
		.aluSrcPc(aluSrcPc),
		.branchFunct(branchFunct),
		.aluResult(aluResult),
		.branchTaken(branchTaken)
	);

	riscvResult uResult (
		.CLK(CLK),
		.RSTn(RSTn),
		.aluResult(aluResult),
		.imm(imm),
		.memData(dMemDi),
		.branchTaken(branchTaken),
		.wbSel(wbSel),
		.pcSel(pcSel),
		.regWrite(regWrite),
		.isHalt(isHalt),
		.pc(pc),
		.rfWe(rfWe),
		.rfWd(rfWd),
		.halt(halt),
		.numInst(numInst)
	);

	assign iMemAddr = pc;
	assign iMemCsn  = RSTn; // Fetch whenever out of reset

	// Strobes are active low
	assign dMemCsn  = !((memRead || memWrite) && !RSTn);
	assign dMemWen  = !(memWrite && !RSTn && !halt);
	assign dMemBe   = 4'b1111; // Word accesses only
	assign dMemAddr = aluResult[`DADDR_W+1:2];
	assign dMemDout = rfRd2;

	assign outputPort = rfWd;

endmodule

// ==== verif/riscvTbModels.sv ====
`include "riscv_params.svh"

module riscvTbModels (
	input  logic                CLK,
	input  logic                preload,
	input  logic [`XLEN-1:0]    x1Init,
	input  logic [`XLEN-1:0]    x2Init,
	input  logic [`PC_W-1:0]    iMemAddr,
	output logic [`XLEN-1:0]    iMemDi,
	input  logic                dMemCsn,
	input  logic [`DADDR_W-1:0] dMemAddr,
	input  logic [`XLEN-1:0]    dMemDout,
	output logic [`XLEN-1:0]    dMemDi,
	input  logic                dMemWen,
	input  logic                rfWe,
	input  logic [4:0]          rfRa1,
	input  logic [4:0]          rfRa2,
	input  logic [4:0]          rfWa1,
	input  logic [`XLEN-1:0]    rfWd,
	output logic [`XLEN-1:0]    rfRd1,
	output logic [`XLEN-1:0]    rfRd2
);
	logic [31:0] imem [0:63];
	logic [31:0] dmem [0:(1<<`DADDR_W)-1];
	logic [31:0] regs [0:31];

	function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	initial begin
		for (int i = 0; i < 64; i++) imem[i] = `EBREAK_INSN;
		for (int i = 0; i < (1<<`DADDR_W); i++) dmem[i] = 32'hD00D_0000 ^ (i * 32'h9E37);
		for (int i = 0; i < 32; i++) regs[i] = '0;
		imem[0]  = encR(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);  // add
		imem[1]  = encR(7'h20, 5'd2, 5'd1, 3'b000, 5'd4);  // sub
		imem[2]  = encR(7'h00, 5'd2, 5'd1, 3'b001, 5'd5);
		imem[3]  = encR(7'h00, 5'd2, 5'd1, 3'b010, 5'd6);
		imem[4]  = encR(7'h00, 5'd2, 5'd1, 3'b011, 5'd7);
		imem[5]  = encR(7'h00, 5'd2, 5'd1, 3'b100, 5'd8);
		imem[6]  = encR(7'h00, 5'd2, 5'd1, 3'b101, 5'd9);
		imem[7]  = encR(7'h20, 5'd2, 5'd1, 3'b101, 5'd10); // sra
		imem[8]  = encR(7'h00, 5'd2, 5'd1, 3'b110, 5'd11);
		imem[9]  = encR(7'h00, 5'd2, 5'd1, 3'b111, 5'd12);
		imem[10] = encI(12'hFFB, 5'd1, 3'b000, 5'd13, 7'b0010011); // addi -5
		imem[11] = encI(12'hFFF, 5'd1, 3'b010, 5'd14, 7'b0010011);
		imem[12] = encI(12'hFFF, 5'd1, 3'b011, 5'd15, 7'b0010011);
		imem[13] = encI(12'h555, 5'd1, 3'b100, 5'd16, 7'b0010011);
		imem[14] = encI(12'h0F0, 5'd1, 3'b110, 5'd17, 7'b0010011);
		imem[15] = encI(12'h7FF, 5'd1, 3'b111, 5'd18, 7'b0010011);
		imem[16] = encI(12'h007, 5'd1, 3'b001, 5'd19, 7'b0010011);
		imem[17] = encI(12'h009, 5'd1, 3'b101, 5'd20, 7'b0010011);
		imem[18] = encI(12'h409, 5'd1, 3'b101, 5'd21, 7'b0010011); // srai 9
		imem[19] = {20'h12345, 5'd22, 7'b0110111};                 // lui
		imem[20] = {20'h00001, 5'd23, 7'b0010111};                 // auipc
		imem[21] = {7'd2, 5'd2, 5'd0, 3'b010, 5'd0, 7'b0100011};   // sw x2, 64(x0)
		imem[22] = encI(12'd64, 5'd0, 3'b010, 5'd24, 7'b0000011);
		imem[23] = encB(13'd8, 5'd1, 5'd1, 3'b000);                // beq taken
		imem[24] = encI(12'd1, 5'd0, 3'b000, 5'd31, 7'b0010011);   // Marker
		imem[25] = encB(13'd8, 5'd1, 5'd1, 3'b001);                // bne not taken
		imem[26] = {1'b0, 10'd4, 1'b0, 8'd0, 5'd25, 7'b1101111};   // jal +8
		imem[27] = encI(12'd2, 5'd0, 3'b000, 5'd31, 7'b0010011);
		imem[28] = encI(12'd129, 5'd0, 3'b000, 5'd26, 7'b0010011);
		imem[29] = encI(12'd0, 5'd26, 3'b000, 5'd27, 7'b1100111);  // jalr
		imem[30] = encI(12'd3, 5'd0, 3'b000, 5'd31, 7'b0010011);
		imem[31] = encI(12'd4, 5'd0, 3'b000, 5'd31, 7'b0010011);
		imem[32] = encB(13'd8, 5'd1, 5'd1, 3'b101);                // bge taken
		imem[33] = encI(12'd5, 5'd0, 3'b000, 5'd31, 7'b0010011);
		imem[34] = encB(13'd8, 5'd0, 5'd2, 3'b110);                // bltu not taken
		imem[35] = `EBREAK_INSN;
	end

	assign iMemDi = imem[iMemAddr[7:2]];
	assign dMemDi = dmem[dMemAddr];
	assign rfRd1  = (rfRa1 == 5'd0) ? '0 : regs[rfRa1];
	assign rfRd2  = (rfRa2 == 5'd0) ? '0 : regs[rfRa2];

	always @(posedge CLK) begin
		if (preload) begin
			regs[1] <= x1Init;
			regs[2] <= x2Init;
		end else if (rfWe && rfWa1 != 5'd0) begin
			regs[rfWa1] <= rfWd;
		end
		if (!dMemCsn && !dMemWen) dmem[dMemAddr] <= dMemDout;
	end

endmodule

// ==== verif/riscvTb.sv ====
`include "riscv_params.svh"

module riscvTb;
	logic CLK;
	logic RSTn;
	logic [31:0] a, b;
	logic iMemCsn, dMemCsn, dMemWen, rfWe, halt;
	logic [`PC_W-1:0] iMemAddr;
	logic [`DADDR_W-1:0] dMemAddr;
	logic [31:0] iMemDi, dMemDout, dMemDi, rfWd, rfRd1, rfRd2, numInst, outputPort;
	logic [3:0] dMemBe;
	logic [4:0] rfRa1, rfRa2, rfWa1;
	logic [31:0] expWd [0:63];
	logic expWe [0:63];
	logic isMarker [0:63];
	logic [`PC_W-1:0] expNext [0:63];
	logic visited [0:63];
	logic [5:0] idx;
	logic [31:0] expWdNow;

	riscvTop i_dut (.*);
	riscvTbModels uModels (.CLK(CLK), .preload(RSTn), .x1Init(a), .x2Init(b), .*);

	assign idx      = iMemAddr[7:2];
	assign expWdNow = expWd[idx];

	always #4 CLK = ~CLK;

	task automatic reportValue(input string name, input logic [`PC_W-1:0] pc,
			input logic [31:0] exp, input logic [31:0] act);
		$display("[FAIL] %s at pc %h expected %h actual %h", name, pc, exp, act);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic reportProblem(input string what);
		$display("Error: %s", what);
		$display("Test failures found");
		$fatal(1);
	endtask

	// Expected results per word address on the program path
	task automatic buildExpected();
		for (int i = 0; i < 64; i++) begin
			expWd[i] = '0;
			expWe[i] = 1'b0;
			isMarker[i] = 1'b0;
			expNext[i] = 12'(i * 4 + 4);
			visited[i] = 1'b0;
		end
		expWd[0]  = a + b;
		expWd[1]  = a - b;
		expWd[2]  = a << b[4:0];
		expWd[3]  = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		expWd[4]  = (a < b) ? 32'd1 : 32'd0;
		expWd[5]  = a ^ b;
		expWd[6]  = a >> b[4:0];
		expWd[7]  = $unsigned($signed(a) >>> b[4:0]);
		expWd[8]  = a | b;
		expWd[9]  = a & b;
		expWd[10] = a - 32'd5;
		expWd[11] = ($signed(a) < -32'sd1) ? 32'd1 : 32'd0;
		expWd[12] = (a < 32'hFFFF_FFFF) ? 32'd1 : 32'd0;
		expWd[13] = a ^ 32'h555;
		expWd[14] = a | 32'h0F0;
		expWd[15] = a & 32'h7FF;
		expWd[16] = a << 7;
		expWd[17] = a >> 9;
		expWd[18] = $unsigned($signed(a) >>> 9);
		expWd[19] = 32'h1234_5000;
		expWd[20] = 32'h0000_1000 + 32'd80;
		expWd[22] = b;           // Loaded back from the stored word
		expWd[26] = 32'd108;     // jal link
		expWd[28] = 32'd129;
		expWd[29] = 32'd120;     // jalr link
		for (int i = 0; i <= 29; i++) begin
			expWe[i] = (i != 21 && i != 23 && i != 25 && i != 24 && i != 27);
		end
		isMarker[24] = 1'b1;
		isMarker[27] = 1'b1;
		isMarker[30] = 1'b1;
		isMarker[31] = 1'b1;
		isMarker[33] = 1'b1;
		expNext[23] = 12'd100;
		expNext[26] = 12'd112;
		expNext[29] = 12'd128;   // 129 with bit 0 cleared
		expNext[32] = 12'd136;
	endtask

	function automatic logic pathReached();
		logic ok;
		ok = 1'b1;
		for (int i = 0; i < 35; i++) if (!isMarker[i] && !visited[i]) ok = 1'b0;
		return ok;
	endfunction

	always @(posedge CLK) begin
		if (!RSTn && !halt) visited[idx] <= 1'b1;
	end

	chkReset: assert property (@(posedge CLK) (RSTn && $past(RSTn)) |-> (iMemAddr == 0
		&& numInst == 0 && !rfWe && dMemWen && iMemCsn && dMemCsn))
		else reportProblem("outputs not in their reset state while reset is held");
	chkFetch: assert property (@(posedge CLK) disable iff (RSTn) !iMemCsn)
		else reportProblem("instruction memory deselected while the core runs");
	chkWe: assert property (@(posedge CLK) disable iff (RSTn) !halt |-> rfWe == expWe[idx])
		else reportValue("rfWe", $sampled(iMemAddr), 32'(expWe[$sampled(idx)]),
			32'($sampled(rfWe)));
	chkWd: assert property (@(posedge CLK) disable iff (RSTn) rfWe |-> rfWd == expWdNow)
		else reportValue("rfWd", $sampled(iMemAddr), $sampled(expWdNow), $sampled(rfWd));
	chkPort: assert property (@(posedge CLK) disable iff (RSTn)
		rfWe |-> outputPort == expWdNow)
		else reportValue("outputPort", $sampled(iMemAddr), $sampled(expWdNow),
			$sampled(outputPort));
	chkNext: assert property (@(posedge CLK) disable iff (RSTn)
		!halt |=> iMemAddr == $past(expNext[idx]))
		else reportValue("nextPc", $sampled(iMemAddr), 32'($past(expNext[idx])),
			32'($sampled(iMemAddr)));
	chkStore: assert property (@(posedge CLK) disable iff (RSTn) (idx == 6'd21) |->
		(!dMemWen && !dMemCsn && dMemAddr == 12'd16 && dMemBe == 4'hF && dMemDout == b))
		else reportValue("sw", $sampled(iMemAddr), b, $sampled(dMemDout));
	chkLoad: assert property (@(posedge CLK) disable iff (RSTn) (idx == 6'd22) |->
		(!dMemCsn && dMemWen && dMemAddr == 12'd16))
		else reportProblem("load did not read data memory at word 16");
	chkNoStray: assert property (@(posedge CLK) disable iff (RSTn) (idx != 6'd21) |-> dMemWen)
		else reportProblem("data memory written outside the store instruction");
	chkMarker: assert property (@(posedge CLK) disable iff (RSTn) !(rfWe && isMarker[idx]))
		else reportProblem("a skipped marker instruction wrote the register file");
	chkHaltHold: assert property (@(posedge CLK) disable iff (RSTn)
		halt |=> (halt && $stable(iMemAddr) && !rfWe))
		else reportProblem("halt dropped, fetch moved or a write happened after EBREAK");
	chkHaltAt: assert property (@(posedge CLK) disable iff (RSTn) halt |-> iMemAddr == 12'd140)
		else reportValue("haltPc", $sampled(iMemAddr), 32'd140, 32'($sampled(iMemAddr)));
	chkCount: assert property (@(posedge CLK) disable iff (RSTn) halt |-> numInst == 32'd30)
		else reportValue("numInst", $sampled(iMemAddr), 32'd30, $sampled(numInst));

	// Watchdog allows 4 cycles per instruction plus reset
	initial begin
		#(36 * 8 * 4 + 4 * 8);
		reportProblem("timeout, halt never reached");
	end

	initial begin
		CLK = 1'b0;
		RSTn = 1'b1;
		void'($urandom(27752));
		a = $urandom;
		b = $urandom;
		buildExpected();
		repeat (4) @(posedge CLK);
		RSTn <= 1'b0;
		do @(posedge CLK); while (!halt);
		repeat (3) @(posedge CLK);
		if (pathReached()) begin
			$display("All tests passed!");
			$finish;
		end else begin
			reportProblem("some instructions on the program path were never fetched");
		end
	end

endmodule

// ==== build.f ====
+incdir+design
design/riscvPkg.sv
design/riscvDecode.sv
design/riscvExecute.sv
design/riscvResult.sv
design/riscvTop.sv
verif/riscvTbModels.sv
verif/riscvTb.sv

// ==== run.sh ====
#!/bin/bash
# Build the core and testbench with Verilator, then run the simulation
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module riscvTb -o simv \
	&& ./obj_dir/simv | tee /dev/stderr | grep -q "All tests passed!" \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
